// ==== include/vlb_defines.svh ====
`ifndef VLB_DEFINES_SVH
`define VLB_DEFINES_SVH

// queue-size word and queue count, one queue per ToR
`define VLB_ADDR_W       32
`define VLB_QUEUE_NUM    8

// fabric shape
`define VLB_SLOT_NUM     2
`define VLB_OCS_NUM      2

// controller frame carrying the slot ID
`define VLB_SLOT_ID_TYPE 16'hff03

// packets one slot can carry
`define VLB_SLOT_MAX_PKT 32'h0004_0000

`define VLB_MY_TOR       0

`endif

// ==== list.f ====
+incdir+include
verilog/vlb_pkg.sv
verilog/relay_budget_if.sv
verilog/slot_ctrl_parser.sv
verilog/queue_snapshot.sv
verilog/relay_allocator.sv
verilog/vlb_top.sv
testbench/tb_vlb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the relay-budget testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_vlb_top -o tb_vlb_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_vlb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -x "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== include/tb_vlb_model.svh ====
`ifndef TB_VLB_MODEL_SVH
`define TB_VLB_MODEL_SVH

// expected free space per queue
queue_size_t model_avail [`VLB_QUEUE_NUM];
tor_id_t     model_n0;
tor_id_t     model_n1;

function automatic queue_size_t min_of(input queue_size_t a, input queue_size_t b);
    return (a < b) ? a : b;
endfunction

// neighbours belong to the slot after the current one
task automatic model_load(input queue_vec_t loc, input queue_vec_t unl, input int slot);
    int next;
    int hop;
    next = (slot + 1) % `VLB_SLOT_NUM;
    hop = (`VLB_MY_TOR + 1 + 2 * next) % `VLB_QUEUE_NUM;
    model_n0 = tor_id_t'(hop);
    hop = (`VLB_MY_TOR - 1 - 2 * next) % `VLB_QUEUE_NUM;
    if (hop < 0) begin
        hop = hop + `VLB_QUEUE_NUM;
    end
    model_n1 = tor_id_t'(hop);
    for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
        model_avail[tor_id_t'(q)] = `VLB_SLOT_MAX_PKT - loc[tor_id_t'(q)] - unl[tor_id_t'(q)];
    end
endtask

// OCS0 first, OCS1 takes what capacity is left
task automatic model_relay(input queue_vec_t offer, input queue_size_t cap,
                           output queue_vec_t relay);
    queue_size_t r0;
    queue_size_t r1;
    r0 = min_of(min_of(offer[model_n0], cap), model_avail[model_n0]);
    r1 = min_of(min_of(offer[model_n1], cap - r0), model_avail[model_n1]);
    relay = '0;
    relay[model_n0] = r0;
    relay[model_n1] = r1;
    model_avail[model_n0] = model_avail[model_n0] - r0;
    model_avail[model_n1] = model_avail[model_n1] - r1;
endtask

`endif

// ==== testbench/tb_vlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vlb_defines.svh"

module tb_vlb_top;
    import vlb_pkg::*;

    localparam int TIMEOUT = 200;

    logic        i_clk;
    logic        i_rst;
    logic        i_ctrl_tvalid;
    logic [63:0] i_ctrl_tdata;
    logic        i_ctrl_tlast;
    logic        o_check_queue_req_valid;
    logic        i_check_queue_resp_ready;
    queue_vec_t  i_local_queue_size;
    queue_vec_t  i_unlocal_queue_size;
    queue_vec_t  i_port0_offer;
    queue_size_t i_port0_offer_capacity;
    logic        i_port0_offer_valid;
    queue_vec_t  i_port1_offer;
    queue_size_t i_port1_offer_capacity;
    logic        i_port1_offer_valid;
    queue_vec_t  o_port0_relay;
    logic        o_port0_relay_valid;
    queue_vec_t  o_port1_relay;
    logic        o_port1_relay_valid;

    logic [31:0] lfsr;
    int          error_count;
    int          timeout_count;

    `include "tb_vlb_model.svh"

    vlb_top uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic end_run();
        $display("errors %0d (mismatches %0d, timeouts %0d)",
                 error_count + timeout_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        timeout_count++;
        $display("gave up waiting for %s", what);
        end_run();
    endtask

    task automatic compare_relay(input string name, input queue_vec_t expected,
                                 input queue_vec_t actual);
        for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
            check_value($sformatf("%s q%0d", name, q), expected[tor_id_t'(q)],
                        actual[tor_id_t'(q)]);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            check_value({name, " request"}, 32'd0, {31'd0, o_check_queue_req_valid});
            check_value({name, " relay0"}, 32'd0, {31'd0, o_port0_relay_valid});
            check_value({name, " relay1"}, 32'd0, {31'd0, o_port1_relay_valid});
        end
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (o_check_queue_req_valid !== level) begin
            @(negedge i_clk);
            n++;
            if (n > TIMEOUT) begin
                give_up("the queue check request");
            end
        end
    endtask

    task automatic wait_relay(input int port, output queue_vec_t relay);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        relay = '0;
        while (!seen) begin
            @(negedge i_clk);
            n++;
            if (port == 0) begin
                seen = o_port0_relay_valid;
                relay = o_port0_relay;
                // port 1 never finishes ahead of port 0
                check_value("relay order", 32'd0, {31'd0, o_port1_relay_valid});
            end else begin
                seen = o_port1_relay_valid;
                relay = o_port1_relay;
            end
            if (!seen && n > TIMEOUT) begin
                give_up("a relay result");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // three beats, beat 1 carries the ether-type
    task automatic send_frame(input logic [15:0] eth_type, input logic [15:0] payload);
        for (int b = 0; b < 3; b++) begin
            @(negedge i_clk);
            i_ctrl_tvalid = 1'b1;
            if (b == 1) begin
                i_ctrl_tdata = {rand_bits(32), eth_type, payload};
            end else begin
                i_ctrl_tdata = {rand_bits(32), rand_bits(32)};
            end
            i_ctrl_tlast = (b == 2);
        end
        @(negedge i_clk);
        i_ctrl_tvalid = 1'b0;
        i_ctrl_tlast = 1'b0;
    endtask

    task automatic start_slot(input int slot);
        for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
            i_local_queue_size[tor_id_t'(q)] = rand_bits(14);
            i_unlocal_queue_size[tor_id_t'(q)] = rand_bits(14);
        end
        send_frame(`VLB_SLOT_ID_TYPE, 16'(slot));
        wait_req(1'b1);
        // no response yet, so the request holds
        repeat (4) begin
            @(negedge i_clk);
            check_value("request held", 32'd1, {31'd0, o_check_queue_req_valid});
        end
        i_check_queue_resp_ready = 1'b1;
        wait_req(1'b0);
        @(negedge i_clk);
        i_check_queue_resp_ready = 1'b0;
        model_load(i_local_queue_size, i_unlocal_queue_size, slot);
    endtask

    task automatic run_offers(input logic use0, input logic use1, input string name);
        queue_vec_t exp0;
        queue_vec_t exp1;
        queue_vec_t got;
        @(negedge i_clk);
        for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
            i_port0_offer[tor_id_t'(q)] = rand_bits(18);
            i_port1_offer[tor_id_t'(q)] = rand_bits(18);
        end
        i_port0_offer_capacity = rand_bits(19);
        i_port1_offer_capacity = rand_bits(19);
        i_port0_offer_valid = use0;
        i_port1_offer_valid = use1;
        // port 0 is served first
        if (use0) begin
            model_relay(i_port0_offer, i_port0_offer_capacity, exp0);
        end
        if (use1) begin
            model_relay(i_port1_offer, i_port1_offer_capacity, exp1);
        end
        @(negedge i_clk);
        i_port0_offer_valid = 1'b0;
        i_port1_offer_valid = 1'b0;
        if (use0) begin
            wait_relay(0, got);
            compare_relay({name, " port0"}, exp0, got);
        end
        if (use1) begin
            wait_relay(1, got);
            compare_relay({name, " port1"}, exp1, got);
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] pick;
        lfsr = 32'h8bb7_0ac4;
        error_count = 0;
        timeout_count = 0;
        i_rst = 1'b1;
        i_ctrl_tvalid = 1'b0;
        i_ctrl_tdata = '0;
        i_ctrl_tlast = 1'b0;
        i_check_queue_resp_ready = 1'b0;
        i_local_queue_size = '0;
        i_unlocal_queue_size = '0;
        i_port0_offer = '0;
        i_port0_offer_capacity = '0;
        i_port0_offer_valid = 1'b0;
        i_port1_offer = '0;
        i_port1_offer_capacity = '0;
        i_port1_offer_valid = 1'b0;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        expect_quiet("after reset", 20);
        send_frame(16'h0800, 16'h0000);
        expect_quiet("wrong ether-type", 12);

        start_slot(0);
        run_offers(1'b1, 1'b0, "slot0 first");
        for (int i = 0; i < 24; i++) begin
            pick = rand_bits(2);
            if (pick == 32'd0) begin
                run_offers(1'b1, 1'b0, $sformatf("slot0 rand%0d", i));
            end else if (pick == 32'd1) begin
                run_offers(1'b0, 1'b1, $sformatf("slot0 rand%0d", i));
            end else begin
                run_offers(1'b1, 1'b1, $sformatf("slot0 rand%0d", i));
            end
        end

        // other slot, other neighbours and a fresh budget
        start_slot(1);
        for (int i = 0; i < 12; i++) begin
            pick = rand_bits(1);
            run_offers(1'b1, pick[0], $sformatf("slot1 rand%0d", i));
        end

        end_run();
    end

endmodule

`default_nettype wire

// ==== verilog/queue_snapshot.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vlb_defines.svh"

module queue_snapshot (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_slot_start_en,
    input  wire vlb_pkg::slot_id_t   i_slot_id,
    input  wire vlb_pkg::queue_vec_t i_local_queue_size,
    input  wire vlb_pkg::queue_vec_t i_unlocal_queue_size,
    relay_budget_if.budget_mp    bif
);
    import vlb_pkg::*;

    queue_vec_t                  r_local_size;
    queue_vec_t                  r_unlocal_size;
    queue_vec_t                  r_avail;
    tor_id_t [`VLB_OCS_NUM-1:0]  r_next_hop;
    logic                        r_load;
    logic                        r_budget_valid;
    slot_id_t                    w_next_slot;
    tor_id_t                     w_hop_ocs0;
    tor_id_t                     w_hop_ocs1;
    logic                        w_grant_over;

    //////////////////////////////////////////////////
    // snapshot at slot start
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_slot_start_en) begin
            r_local_size   <= i_local_queue_size;
            r_unlocal_size <= i_unlocal_queue_size;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_load         <= 1'b0;
            r_budget_valid <= 1'b0;
        end else begin
            r_load <= i_slot_start_en;
            if (r_load) begin
                r_budget_valid <= 1'b1;
            end
        end
    end

    // neighbours of the next slot, OCS0 walks up and OCS1 walks down
    always_comb begin
        w_next_slot = (i_slot_id == slot_id_t'(`VLB_SLOT_NUM - 1)) ? '0 :
                      slot_id_t'(i_slot_id + 1'b1);
        w_hop_ocs0  = tor_id_t'((`VLB_MY_TOR + 1 + 2 * int'(w_next_slot))
                      % `VLB_QUEUE_NUM);
        w_hop_ocs1  = tor_id_t'((`VLB_MY_TOR + 2 * `VLB_QUEUE_NUM - 1 - 2 * int'(w_next_slot))
                      % `VLB_QUEUE_NUM);
    end

    //////////////////////////////////////////////////
    // available space
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (r_load) begin
            for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
                r_avail[q] <= queue_size_t'(`VLB_SLOT_MAX_PKT) - r_local_size[q]
                              - r_unlocal_size[q];
            end
            r_next_hop <= {w_hop_ocs1, w_hop_ocs0};
        end else if (bif.grant_valid) begin
            for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
                r_avail[q] <= r_avail[q] - bif.grant[q];
            end
        end
    end

    assign bif.avail        = r_avail;
    assign bif.next_hop     = r_next_hop;
    assign bif.budget_valid = r_budget_valid;

    always_comb begin
        w_grant_over = 1'b0;
        for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
            if (bif.grant[q] > r_avail[q]) begin
                w_grant_over = 1'b1;
            end
        end
    end

    // allocator never grants more than this store holds
    a_grant_fits: assert property (@(posedge i_clk) disable iff (i_rst)
        bif.grant_valid |-> !w_grant_over);

endmodule

`default_nettype wire

// ==== verilog/relay_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vlb_defines.svh"

module relay_allocator (
    input  wire                      i_clk,
    input  wire                      i_rst,
    input  wire vlb_pkg::queue_vec_t  i_port0_offer,
    input  wire vlb_pkg::queue_size_t i_port0_offer_capacity,
    input  wire                      i_port0_offer_valid,
    input  wire vlb_pkg::queue_vec_t  i_port1_offer,
    input  wire vlb_pkg::queue_size_t i_port1_offer_capacity,
    input  wire                      i_port1_offer_valid,
    output vlb_pkg::queue_vec_t      o_port0_relay,
    output logic                     o_port0_relay_valid,
    output vlb_pkg::queue_vec_t      o_port1_relay,
    output logic                     o_port1_relay_valid,
    relay_budget_if.alloc_mp         bif
);
    import vlb_pkg::*;

    queue_vec_t  w_offer_in [2];
    queue_size_t w_cap_in   [2];
    logic [1:0]  w_valid_in;
    queue_vec_t  r_offer    [2];
    queue_size_t r_cap      [2];
    logic [1:0]  r_pending;
    logic        r_busy;
    logic        r_sel;
    queue_vec_t  r_work_offer;
    queue_size_t r_work_cap;
    logic        w_take;
    logic        w_take_sel;
    tor_id_t     w_n0;
    tor_id_t     w_n1;
    queue_size_t w_r0;
    queue_size_t w_r1;
    queue_vec_t  w_grant;

    function automatic queue_size_t min3(input queue_size_t a, input queue_size_t b,
                                         input queue_size_t c);
        queue_size_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    assign w_offer_in[0] = i_port0_offer;
    assign w_offer_in[1] = i_port1_offer;
    assign w_cap_in[0]   = i_port0_offer_capacity;
    assign w_cap_in[1]   = i_port1_offer_capacity;
    assign w_valid_in    = {i_port1_offer_valid, i_port0_offer_valid};

    //////////////////////////////////////////////////
    // pending offers and arbitration
    //////////////////////////////////////////////////

    // a newer offer replaces a held one
    always_ff @(posedge i_clk) begin
        for (int p = 0; p < 2; p++) begin
            if (w_valid_in[p]) begin
                r_offer[p] <= w_offer_in[p];
                r_cap[p]   <= w_cap_in[p];
            end
        end
    end

    // port 0 wins
    assign w_take     = !r_busy && bif.budget_valid && (|r_pending);
    assign w_take_sel = !r_pending[0];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_pending <= 2'b00;
            r_busy    <= 1'b0;
            r_sel     <= 1'b0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (w_valid_in[p]) begin
                    r_pending[p] <= 1'b1;
                end else if (w_take && (int'(w_take_sel) == p)) begin
                    r_pending[p] <= 1'b0;
                end
            end
            r_busy <= w_take;
            if (w_take) begin
                r_sel <= w_take_sel;
            end
        end
    end

    // working copy so a new offer can land during the compute cycle
    always_ff @(posedge i_clk) begin
        if (w_take) begin
            r_work_offer <= r_offer[w_take_sel];
            r_work_cap   <= r_cap[w_take_sel];
        end
    end

    //////////////////////////////////////////////////
    // relay computation
    //////////////////////////////////////////////////

    always_comb begin
        w_n0 = bif.next_hop[0];
        w_n1 = bif.next_hop[1];
        w_r0 = min3(r_work_offer[w_n0], r_work_cap, bif.avail[w_n0]);
        // OCS1 gets what the port has left after OCS0
        w_r1 = min3(r_work_offer[w_n1], r_work_cap - w_r0, bif.avail[w_n1]);
        for (int q = 0; q < `VLB_QUEUE_NUM; q++) begin
            if (tor_id_t'(q) == w_n0) begin
                w_grant[q] = w_r0;
            end else if (tor_id_t'(q) == w_n1) begin
                w_grant[q] = w_r1;
            end else begin
                w_grant[q] = '0;
            end
        end
    end

    assign bif.grant       = w_grant;
    assign bif.grant_valid = r_busy;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_port0_relay_valid <= 1'b0;
            o_port1_relay_valid <= 1'b0;
        end else begin
            o_port0_relay_valid <= r_busy && !r_sel;
            o_port1_relay_valid <= r_busy && r_sel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_busy && !r_sel) begin
            o_port0_relay <= w_grant;
        end
        if (r_busy && r_sel) begin
            o_port1_relay <= w_grant;
        end
    end

    a_one_relay: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_port0_relay_valid && o_port1_relay_valid));

    for (genvar q = 0; q < `VLB_QUEUE_NUM; q++) begin : g_chk
        a_relay_le_offer: assert property (@(posedge i_clk) disable iff (i_rst)
            (o_port0_relay_valid || o_port1_relay_valid) |->
            ((o_port0_relay_valid ? o_port0_relay[q] : o_port1_relay[q])
             <= $past(r_work_offer[q])));
    end

endmodule

`default_nettype wire

// ==== verilog/relay_budget_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vlb_defines.svh"

interface relay_budget_if;
    import vlb_pkg::*;

    // budget side
    queue_vec_t                  avail;
    tor_id_t [`VLB_OCS_NUM-1:0]  next_hop;
    logic                        budget_valid;

    // allocator side
    queue_vec_t                  grant;
    logic                        grant_valid;

    modport budget_mp (
        output avail, next_hop, budget_valid,
        input  grant, grant_valid
    );

    modport alloc_mp (
        input  avail, next_hop, budget_valid,
        output grant, grant_valid
    );

endinterface

`default_nettype wire

// ==== verilog/slot_ctrl_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vlb_defines.svh"

module slot_ctrl_parser (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_ctrl_tvalid,
    input  wire  [63:0]         i_ctrl_tdata,
    input  wire                 i_ctrl_tlast,
    input  wire                 i_check_queue_resp_ready,
    output logic                o_check_queue_req_valid,
    output logic                o_slot_start_en,
    output vlb_pkg::slot_id_t   o_slot_id
);
    import vlb_pkg::*;

    logic [15:0] r_beat_cnt;
    ctrl_beat_u  w_beat;
    logic        w_slot_hit;
    logic        r_slot_hit;
    logic        r_slot_start;
    logic [2:0]  r_resp_sync;

    //////////////////////////////////////////////////
    // frame decode
    //////////////////////////////////////////////////

    assign w_beat.raw = i_ctrl_tdata;

    // beat 1 holds the ether-type of the frame
    assign w_slot_hit = i_ctrl_tvalid && (r_beat_cnt == 16'd1) &&
                        (w_beat.slot.eth_type == `VLB_SLOT_ID_TYPE);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_beat_cnt <= '0;
        end else if (i_ctrl_tvalid && i_ctrl_tlast) begin
            r_beat_cnt <= '0;
        end else if (i_ctrl_tvalid) begin
            r_beat_cnt <= r_beat_cnt + 16'd1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_slot_hit <= 1'b0;
            o_slot_id  <= '0;
        end else begin
            r_slot_hit <= w_slot_hit;
            if (w_slot_hit) begin
                o_slot_id <= slot_id_t'(w_beat.slot.payload);
            end
        end
    end

    //////////////////////////////////////////////////
    // queue check handshake
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_slot_start            <= 1'b0;
            o_check_queue_req_valid <= 1'b0;
            r_resp_sync             <= 3'b000;
            o_slot_start_en         <= 1'b0;
        end else begin
            // a frame during an open check is dropped
            r_slot_start <= r_slot_hit && !o_check_queue_req_valid;
            if (r_resp_sync[2]) begin
                o_check_queue_req_valid <= 1'b0;
            end else if (r_slot_start) begin
                o_check_queue_req_valid <= 1'b1;
            end
            r_resp_sync     <= {r_resp_sync[1:0], i_check_queue_resp_ready};
            o_slot_start_en <= r_resp_sync[1] && !r_resp_sync[2];
        end
    end

    // the queue side must drop its level before the next check
    a_req_after_resp: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_check_queue_req_valid) |-> !r_resp_sync[2]);

endmodule

`default_nettype wire

// ==== verilog/vlb_pkg.sv ====
`default_nettype none

`include "vlb_defines.svh"

package vlb_pkg;

    //////////////////////////////////////////////////
    // queue and index types
    //////////////////////////////////////////////////

    typedef logic [`VLB_ADDR_W-1:0] queue_size_t;

    typedef queue_size_t [`VLB_QUEUE_NUM-1:0] queue_vec_t;

    typedef logic [$clog2(`VLB_QUEUE_NUM)-1:0] tor_id_t;

    typedef logic [$clog2(`VLB_SLOT_NUM)-1:0] slot_id_t;

    //////////////////////////////////////////////////
    // controller stream beat
    //////////////////////////////////////////////////

    // second beat of a slot frame
    typedef struct packed {
        logic [31:0] mac_low;
        logic [15:0] eth_type;
        logic [15:0] payload;
    } slot_beat_s;

    typedef union packed {
        logic [63:0] raw;
        slot_beat_s  slot;
    } ctrl_beat_u;

endpackage

`default_nettype wire

// ==== verilog/vlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vlb_top (
    input  wire                      i_clk,
    input  wire                      i_rst,
    input  wire                      i_ctrl_tvalid,
    input  wire  [63:0]              i_ctrl_tdata,
    input  wire                      i_ctrl_tlast,
    output logic                     o_check_queue_req_valid,
    input  wire                      i_check_queue_resp_ready,
    input  wire vlb_pkg::queue_vec_t  i_local_queue_size,
    input  wire vlb_pkg::queue_vec_t  i_unlocal_queue_size,
    input  wire vlb_pkg::queue_vec_t  i_port0_offer,
    input  wire vlb_pkg::queue_size_t i_port0_offer_capacity,
    input  wire                      i_port0_offer_valid,
    input  wire vlb_pkg::queue_vec_t  i_port1_offer,
    input  wire vlb_pkg::queue_size_t i_port1_offer_capacity,
    input  wire                      i_port1_offer_valid,
    output vlb_pkg::queue_vec_t      o_port0_relay,
    output logic                     o_port0_relay_valid,
    output vlb_pkg::queue_vec_t      o_port1_relay,
    output logic                     o_port1_relay_valid
);
    import vlb_pkg::*;

    logic     slot_start_en;
    slot_id_t slot_id;

    relay_budget_if bif ();

    slot_ctrl_parser u_parser (
        .i_clk                    (i_clk),
        .i_rst                    (i_rst),
        .i_ctrl_tvalid            (i_ctrl_tvalid),
        .i_ctrl_tdata             (i_ctrl_tdata),
        .i_ctrl_tlast             (i_ctrl_tlast),
        .i_check_queue_resp_ready (i_check_queue_resp_ready),
        .o_check_queue_req_valid  (o_check_queue_req_valid),
        .o_slot_start_en          (slot_start_en),
        .o_slot_id                (slot_id)
    );

    queue_snapshot u_snapshot (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .i_slot_start_en      (slot_start_en),
        .i_slot_id            (slot_id),
        .i_local_queue_size   (i_local_queue_size),
        .i_unlocal_queue_size (i_unlocal_queue_size),
        .bif                  (bif.budget_mp)
    );

    relay_allocator u_allocator (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_port0_offer          (i_port0_offer),
        .i_port0_offer_capacity (i_port0_offer_capacity),
        .i_port0_offer_valid    (i_port0_offer_valid),
        .i_port1_offer          (i_port1_offer),
        .i_port1_offer_capacity (i_port1_offer_capacity),
        .i_port1_offer_valid    (i_port1_offer_valid),
        .o_port0_relay          (o_port0_relay),
        .o_port0_relay_valid    (o_port0_relay_valid),
        .o_port1_relay          (o_port1_relay),
        .o_port1_relay_valid    (o_port1_relay_valid),
        .bif                    (bif.alloc_mp)
    );

endmodule

`default_nettype wire
